// ==== Bender.yml ====
package:
  name: alloc_top

sources:
  - core_pkg.sv
  - rename_map.sv
  - robid_alloc.sv
  - alloc_cfg_regs.sv
  - alloc.sv
  - rs_buffer.sv
  - alloc_top.sv
  - target: test
    files:
      - tb_alloc_top.sv

// ==== alloc.sv ====
`timescale 1ns/1ps

module alloc #(
   parameter int RS_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  valid_in,
   input  core_pkg::t_uinstr     uinstr_in,
   input  core_pkg::t_rename_pkt rename_in,
   input  core_pkg::t_nuke_pkt   nuke_in,
   input  logic [7:0]            credit_limit,
   input  logic                  dispatch_enable,
   input  logic                  robid_full,
   input  logic                  credit_return,
   output logic                  ready_out,
   output logic                  accept,
   output logic                  disp_valid,
   output core_pkg::t_disp_pkt   disp_pkt
);

   core_pkg::t_disp_pkt disp_pkt_ra0;
   core_pkg::t_disp_pkt disp_pkt_ra1;
   logic                valid_ra1_q;

   logic [7:0] credit_cnt;
   logic [7:0] credit_step;
   logic [7:0] credit_next;
   logic [7:0] reload_val;
   logic       reload_q;
   logic       credit_avail;

   // ==================================================
   // RA0: accept and build the packet
   // ==================================================

   // The micro-op sitting in RA1 has not spent its credit yet.
   assign credit_avail = credit_cnt > {7'd0, valid_ra1_q};
   assign ready_out    = credit_avail && !robid_full && dispatch_enable && !nuke_in.valid;
   assign accept       = valid_in && ready_out;

   always_comb begin
      disp_pkt_ra0.uinstr = uinstr_in;
      disp_pkt_ra0.rename = rename_in;
      disp_pkt_ra0.meta   = '0;
   end

   // ==================================================
   // RA1: registered dispatch
   // ==================================================

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_ra1_q <= 1'b0;
      end else begin
         valid_ra1_q <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         disp_pkt_ra1 <= disp_pkt_ra0;
      end
   end

   // A flush in this cycle kills the packet before it reaches the buffer.
   assign disp_valid = valid_ra1_q && !nuke_in.valid;
   assign disp_pkt   = disp_pkt_ra1;

   // ==================================================
   // Credits
   // ==================================================

   assign reload_val = (credit_limit > 8'(RS_DEPTH)) ? 8'(RS_DEPTH) : credit_limit;

   // A lowered limit trims the counter, and returns then only refill up to it.
   always_comb begin
      credit_step = credit_cnt - {7'd0, disp_valid} + {7'd0, credit_return};
      credit_next = (credit_step > credit_limit) ? credit_limit : credit_step;
   end

   // The counter stays empty through reset and loads on the first cycle after it.
   always_ff @(posedge clk) begin
      if (rst) begin
         reload_q   <= 1'b1;
         credit_cnt <= '0;
      end else begin
         reload_q   <= 1'b0;
         credit_cnt <= (reload_q || nuke_in.valid) ? reload_val : credit_next;
      end
   end

   // The counter can never promise more slots than the buffer holds.
   a_credit_within_depth : assert property (
      @(posedge clk) disable iff (rst) credit_cnt <= 8'(RS_DEPTH)
   ) else $error("alloc: credit counter above the buffer depth");

endmodule

// ==== alloc_cfg_regs.sv ====
`timescale 1ns/1ps

module alloc_cfg_regs #(
   parameter int RS_DEPTH = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  core_pkg::t_cfg_wr cfg_wr,
   output logic [7:0]        credit_limit,
   output logic              dispatch_enable
);

   logic [7:0] limit_wr;

   // A limit above the buffer size would let alloc overrun it.
   assign limit_wr = (cfg_wr.data > 8'(RS_DEPTH)) ? 8'(RS_DEPTH) : cfg_wr.data;

   always_ff @(posedge clk) begin
      if (rst) begin
         credit_limit    <= 8'(RS_DEPTH);
         dispatch_enable <= 1'b1;
      end else if (cfg_wr.valid) begin
         case (cfg_wr.addr)
            core_pkg::CFG_CREDIT_LIMIT_ADDR: credit_limit <= limit_wr;
            core_pkg::CFG_ENABLE_ADDR:       dispatch_enable <= cfg_wr.data[0];
            default: ;
         endcase
      end
   end

   // A limit of zero would stall dispatch for good.
   a_limit_nonzero : assert property (
      @(posedge clk) disable iff (rst)
         (cfg_wr.valid && (cfg_wr.addr == core_pkg::CFG_CREDIT_LIMIT_ADDR))
            |-> (cfg_wr.data != '0)
   ) else $error("alloc_cfg_regs: credit limit written with zero");

endmodule

// ==== alloc_top.sv ====
`timescale 1ns/1ps

module alloc_top #(
   parameter int RS_DEPTH  = 4,
   parameter int ROB_DEPTH = 32
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                valid_in,
   input  core_pkg::t_uinstr   uinstr_in,
   input  core_pkg::t_nuke_pkt nuke_in,
   input  logic                retire_valid,
   input  core_pkg::t_cfg_wr   cfg_wr,
   input  logic                issue_ready,
   output logic                ready_out,
   output logic                issue_valid,
   output core_pkg::t_disp_pkt issue_pkt
);

   core_pkg::t_rename_pkt rename;
   core_pkg::t_disp_pkt   disp_pkt;
   core_pkg::t_rob_id     oldest_robid;
   logic                  robid_full;
   logic                  accept;
   logic                  disp_valid;
   logic                  credit_return;
   logic [7:0]            credit_limit;
   logic                  dispatch_enable;

   rename_map u_rename_map (
      .clk          (clk),
      .rst          (rst),
      .src1_addr    (uinstr_in.src1.addr),
      .src2_addr    (uinstr_in.src2.addr),
      .wr_valid     (accept && uinstr_in.dst.used),
      .wr_addr      (uinstr_in.dst.addr),
      .wr_robid     (rename.robid),
      .retire_valid (retire_valid),
      .retire_robid (oldest_robid),
      .nuke         (nuke_in.valid),
      .src1_pending (rename.psrc1.pending),
      .src2_pending (rename.psrc2.pending),
      .src1_robid   (rename.psrc1.robid),
      .src2_robid   (rename.psrc2.robid)
   );

   robid_alloc #(.ROB_DEPTH(ROB_DEPTH)) u_robid_alloc (
      .clk          (clk),
      .rst          (rst),
      .alloc_valid  (accept),
      .retire_valid (retire_valid),
      .nuke         (nuke_in.valid),
      .next_robid   (rename.robid),
      .oldest_robid (oldest_robid),
      .full         (robid_full)
   );

   alloc_cfg_regs #(.RS_DEPTH(RS_DEPTH)) u_cfg (
      .clk             (clk),
      .rst             (rst),
      .cfg_wr          (cfg_wr),
      .credit_limit    (credit_limit),
      .dispatch_enable (dispatch_enable)
   );

   alloc #(.RS_DEPTH(RS_DEPTH)) u_alloc (
      .clk             (clk),
      .rst             (rst),
      .valid_in        (valid_in),
      .uinstr_in       (uinstr_in),
      .rename_in       (rename),
      .nuke_in         (nuke_in),
      .credit_limit    (credit_limit),
      .dispatch_enable (dispatch_enable),
      .robid_full      (robid_full),
      .credit_return   (credit_return),
      .ready_out       (ready_out),
      .accept          (accept),
      .disp_valid      (disp_valid),
      .disp_pkt        (disp_pkt)
   );

   rs_buffer #(.RS_DEPTH(RS_DEPTH)) u_rs_buffer (
      .clk           (clk),
      .rst           (rst),
      .disp_valid    (disp_valid),
      .disp_pkt      (disp_pkt),
      .issue_ready   (issue_ready),
      .nuke          (nuke_in.valid),
      .issue_valid   (issue_valid),
      .issue_pkt     (issue_pkt),
      .credit_return (credit_return)
   );

endmodule

// ==== core_pkg.sv ====
package core_pkg;

   // ==================================================
   // Widths
   // ==================================================

   localparam int NUM_ARCH_REGS = 32;
   localparam int REG_ADDR_W    = 5;

   // The ROB holds 2**ROB_ID_W entries.
   localparam int ROB_ID_W = 5;

   typedef logic [REG_ADDR_W-1:0] t_reg_addr;
   typedef logic [ROB_ID_W-1:0]   t_rob_id;

   // ==================================================
   // Micro-op and rename result
   // ==================================================

   // One register operand of a micro-op.
   typedef struct packed {
      logic      used;
      t_reg_addr addr;
   } t_opnd;

   typedef struct packed {
      logic [7:0]  opcode;
      t_opnd       src1;
      t_opnd       src2;
      t_opnd       dst;
      logic [15:0] imm;
      logic [15:0] simid;
   } t_uinstr;

   // Producer of a source operand, valid only while pending is set.
   typedef struct packed {
      t_rob_id robid;
      logic    pending;
   } t_psrc;

   typedef struct packed {
      t_rob_id robid;
      t_psrc   psrc1;
      t_psrc   psrc2;
   } t_rename_pkt;

   // ==================================================
   // Dispatch, flush and config
   // ==================================================

   typedef struct packed {
      t_uinstr     uinstr;
      t_rename_pkt rename;
      logic [3:0]  meta;
   } t_disp_pkt;

   typedef struct packed {
      logic        valid;
      logic [15:0] reason;
   } t_nuke_pkt;

   typedef struct packed {
      logic       valid;
      logic [1:0] addr;
      logic [7:0] data;
   } t_cfg_wr;

   localparam logic [1:0] CFG_CREDIT_LIMIT_ADDR = 2'd0;
   localparam logic [1:0] CFG_ENABLE_ADDR       = 2'd1;

endpackage

// ==== files.f ====
core_pkg.sv
rename_map.sv
robid_alloc.sv
alloc_cfg_regs.sv
alloc.sv
rs_buffer.sv
alloc_top.sv
tb_alloc_top.sv

// ==== rename_map.sv ====
`timescale 1ns/1ps

module rename_map (
   input  logic                clk,
   input  logic                rst,
   input  core_pkg::t_reg_addr src1_addr,
   input  core_pkg::t_reg_addr src2_addr,
   input  logic                wr_valid,
   input  core_pkg::t_reg_addr wr_addr,
   input  core_pkg::t_rob_id   wr_robid,
   input  logic                retire_valid,
   input  core_pkg::t_rob_id   retire_robid,
   input  logic                nuke,
   output logic                src1_pending,
   output logic                src2_pending,
   output core_pkg::t_rob_id   src1_robid,
   output core_pkg::t_rob_id   src2_robid
);

   // Last producer of each architectural register.
   core_pkg::t_rob_id robid_q [core_pkg::NUM_ARCH_REGS];
   logic [core_pkg::NUM_ARCH_REGS-1:0] pending_q;

   logic dst_write;

   // Register 0 is hardwired, so it never gets a producer.
   assign dst_write = wr_valid && (wr_addr != '0);

   // ==================================================
   // Source lookup
   // ==================================================

   // Sources read the map as it stood before this cycle's destination write,
   // so a micro-op that reads and writes the same register sees the older producer.
   assign src1_pending = pending_q[src1_addr];
   assign src2_pending = pending_q[src2_addr];
   assign src1_robid   = robid_q[src1_addr];
   assign src2_robid   = robid_q[src2_addr];

   // ==================================================
   // Map update
   // ==================================================

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < core_pkg::NUM_ARCH_REGS; i++) begin
            robid_q[i] <= '0;
         end
      end else if (dst_write) begin
         robid_q[wr_addr] <= wr_robid;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pending_q <= '0;
      end else if (nuke) begin
         // Every in-flight producer is gone after a flush.
         pending_q <= '0;
      end else begin
         // Retirement clears every register still mapped to the retiring id.
         for (int i = 0; i < core_pkg::NUM_ARCH_REGS; i++) begin
            if (retire_valid && pending_q[i] && (robid_q[i] == retire_robid)) begin
               pending_q[i] <= 1'b0;
            end
         end
         // A new producer wins over a retire on the same register.
         if (dst_write) begin
            pending_q[wr_addr] <= 1'b1;
         end
      end
   end

endmodule

// ==== robid_alloc.sv ====
`timescale 1ns/1ps

module robid_alloc #(
   parameter int ROB_DEPTH = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              alloc_valid,
   input  logic              retire_valid,
   input  logic              nuke,
   output core_pkg::t_rob_id next_robid,
   output core_pkg::t_rob_id oldest_robid,
   output logic              full
);

   localparam int CNT_W = $clog2(ROB_DEPTH + 1);

   // Pointers wrap on their own width, so the depth must fill the id space.
   if (ROB_DEPTH != (1 << core_pkg::ROB_ID_W)) begin : g_depth_check
      $error("robid_alloc: ROB_DEPTH must equal 2**ROB_ID_W");
   end

   core_pkg::t_rob_id head_q;
   core_pkg::t_rob_id tail_q;
   core_pkg::t_rob_id head_next;
   logic [CNT_W-1:0]  count_q;

   assign next_robid   = tail_q;
   assign oldest_robid = head_q;
   assign full         = (count_q == CNT_W'(ROB_DEPTH));

   assign head_next = retire_valid ? head_q + 1'b1 : head_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else if (nuke) begin
         // Drop every younger id. A retire in the same cycle still counts.
         head_q  <= head_next;
         tail_q  <= head_next;
         count_q <= '0;
      end else begin
         head_q  <= head_next;
         tail_q  <= alloc_valid ? tail_q + 1'b1 : tail_q;
         count_q <= count_q + CNT_W'(alloc_valid) - CNT_W'(retire_valid);
      end
   end

   // Retire frees the oldest id, so one has to be outstanding.
   a_no_retire_underflow : assert property (
      @(posedge clk) disable iff (rst) retire_valid |-> (count_q != '0)
   ) else $error("robid_alloc: retire with no robid allocated");

endmodule

// ==== rs_buffer.sv ====
`timescale 1ns/1ps

module rs_buffer #(
   parameter int RS_DEPTH = 4
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                disp_valid,
   input  core_pkg::t_disp_pkt disp_pkt,
   input  logic                issue_ready,
   input  logic                nuke,
   output logic                issue_valid,
   output core_pkg::t_disp_pkt issue_pkt,
   output logic                credit_return
);

   localparam int PTR_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
   localparam int CNT_W = $clog2(RS_DEPTH + 1);

   core_pkg::t_disp_pkt entries [RS_DEPTH];

   logic [PTR_W-1:0] head_q;
   logic [PTR_W-1:0] tail_q;
   logic [CNT_W-1:0] count_q;
   logic             do_issue;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(RS_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // ==================================================
   // Issue side
   // ==================================================

   assign issue_valid = (count_q != '0);
   assign issue_pkt   = entries[head_q];
   assign do_issue    = issue_valid && issue_ready;

   // On a flush alloc reloads its credits, so none come back from here.
   assign credit_return = do_issue && !nuke;

   // ==================================================
   // Storage and pointers
   // ==================================================

   always_ff @(posedge clk) begin
      if (disp_valid) begin
         entries[tail_q] <= disp_pkt;
      end
   end

   always_ff @(posedge clk) begin
      if (rst || nuke) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else begin
         if (disp_valid) begin
            tail_q <= ptr_inc(tail_q);
         end
         if (do_issue) begin
            head_q <= ptr_inc(head_q);
         end
         count_q <= count_q + CNT_W'(disp_valid) - CNT_W'(do_issue);
      end
   end

   // Alloc reserved a slot at acceptance, so a dispatch always finds room.
   a_no_overflow : assert property (
      @(posedge clk) disable iff (rst) disp_valid |-> (count_q < CNT_W'(RS_DEPTH))
   ) else $error("rs_buffer: dispatch into a full buffer");

endmodule

// ==== tb_alloc_top.sv ====
`timescale 1ns/1ps

module tb_alloc_top;

   localparam int RS_DEPTH  = 4;
   localparam int ROB_DEPTH = 32;
   localparam int TIMEOUT   = 200;

   logic                clk;
   logic                rst;
   logic                valid_in;
   core_pkg::t_uinstr   uinstr_in;
   core_pkg::t_nuke_pkt nuke_in;
   logic                retire_valid;
   core_pkg::t_cfg_wr   cfg_wr;
   logic                issue_ready;
   logic                ready_out;
   logic                issue_valid;
   core_pkg::t_disp_pkt issue_pkt;

   // Reference model state, updated at every rising edge.
   core_pkg::t_disp_pkt exp_q [$];
   core_pkg::t_disp_pkt exp_head;
   core_pkg::t_rob_id   map_m [core_pkg::NUM_ARCH_REGS];
   logic [31:0]         pend_m;
   core_pkg::t_rob_id   head_m;
   core_pkg::t_rob_id   tail_m;
   logic                ra1_m;
   logic                enable_m;
   logic                ready_exp;
   int                  exp_count;
   int                  buf_cnt_m;
   int                  rob_cnt_m;
   int                  limit_m;
   int                  accepted_total;

   string       test_name;
   integer      seed;
   logic [15:0] uop_id;
   logic        credit_track;
   logic        fill_chk;
   logic        rob_chk;
   int          fill_expect;

   alloc_top #(.RS_DEPTH(RS_DEPTH), .ROB_DEPTH(ROB_DEPTH)) u_dut (
      .clk          (clk),
      .rst          (rst),
      .valid_in     (valid_in),
      .uinstr_in    (uinstr_in),
      .nuke_in      (nuke_in),
      .retire_valid (retire_valid),
      .cfg_wr       (cfg_wr),
      .issue_ready  (issue_ready),
      .ready_out    (ready_out),
      .issue_valid  (issue_valid),
      .issue_pkt    (issue_pkt)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ==================================================
   // Reporting and packet compare
   // ==================================================

   task automatic report_mismatch(input string check, input logic [127:0] expected,
                                  input logic [127:0] actual);
      $display("FAILED %s (%s): expected %0h, actual %0h", test_name, check, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "check %s did not hold", check);
   endtask

   task automatic abort_run(input string why);
      $display("ERROR in %s: %s", test_name, why);
      $display("FAIL: see errors above");
      $fatal(1, "run aborted");
   endtask

   function automatic logic pkt_match(input core_pkg::t_disp_pkt e,
                                      input core_pkg::t_disp_pkt a);
      logic ok;
      ok = (a.uinstr == e.uinstr) && (a.rename.robid == e.rename.robid) && (a.meta == 4'd0);
      ok = ok && (a.rename.psrc1.pending == e.rename.psrc1.pending);
      ok = ok && (a.rename.psrc2.pending == e.rename.psrc2.pending);
      // A producer id only means something while its source is pending.
      if (e.rename.psrc1.pending) begin
         ok = ok && (a.rename.psrc1.robid == e.rename.psrc1.robid);
      end
      if (e.rename.psrc2.pending) begin
         ok = ok && (a.rename.psrc2.robid == e.rename.psrc2.robid);
      end
      return ok;
   endfunction

   // ==================================================
   // Reference model
   // ==================================================

   always @(posedge clk) begin : ref_model
      core_pkg::t_disp_pkt pkt;
      logic issued;
      logic accepted;
      issued   = issue_valid && issue_ready;
      accepted = valid_in && ready_out;
      pkt      = '0;
      if (rst) begin
         exp_q.delete();
         ra1_m     = 1'b0;
         buf_cnt_m = 0;
         rob_cnt_m = 0;
         head_m    = '0;
         tail_m    = '0;
         pend_m    = '0;
         limit_m   = RS_DEPTH;
         enable_m  = 1'b1;
         accepted_total = 0;
      end else begin
         if (issued && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
         end
         buf_cnt_m = buf_cnt_m + int'(ra1_m) - int'(issued);
         ra1_m     = accepted;
         // Sources see the map as it was before this edge.
         if (accepted) begin
            pkt.uinstr              = uinstr_in;
            pkt.rename.robid        = tail_m;
            pkt.rename.psrc1.pending = pend_m[uinstr_in.src1.addr];
            pkt.rename.psrc1.robid   = map_m[uinstr_in.src1.addr];
            pkt.rename.psrc2.pending = pend_m[uinstr_in.src2.addr];
            pkt.rename.psrc2.robid   = map_m[uinstr_in.src2.addr];
            exp_q.push_back(pkt);
            accepted_total++;
         end
         if (retire_valid) begin
            for (int r = 0; r < core_pkg::NUM_ARCH_REGS; r++) begin
               if (pend_m[r] && (map_m[r] == head_m)) begin
                  pend_m[r] = 1'b0;
               end
            end
            head_m = head_m + 1'b1;
         end
         if (accepted && uinstr_in.dst.used && (uinstr_in.dst.addr != '0)) begin
            map_m[uinstr_in.dst.addr]  = tail_m;
            pend_m[uinstr_in.dst.addr] = 1'b1;
         end
         tail_m    = accepted ? tail_m + 1'b1 : tail_m;
         rob_cnt_m = rob_cnt_m + int'(accepted) - int'(retire_valid);
         if (nuke_in.valid) begin
            exp_q.delete();
            ra1_m     = 1'b0;
            buf_cnt_m = 0;
            rob_cnt_m = 0;
            tail_m    = head_m;
            pend_m    = '0;
         end
         if (cfg_wr.valid && (cfg_wr.addr == core_pkg::CFG_CREDIT_LIMIT_ADDR)) begin
            limit_m = (int'(cfg_wr.data) > RS_DEPTH) ? RS_DEPTH : int'(cfg_wr.data);
         end
         if (cfg_wr.valid && (cfg_wr.addr == core_pkg::CFG_ENABLE_ADDR)) begin
            enable_m = cfg_wr.data[0];
         end
      end
      exp_count = exp_q.size();
      exp_head  = (exp_q.size() != 0) ? exp_q[0] : '0;
   end

   // Input is open while a credit, a robid and the enable are all there.
   assign ready_exp = (exp_count < limit_m) && (rob_cnt_m < ROB_DEPTH) && enable_m
                      && !nuke_in.valid;

   // ==================================================
   // Checks
   // ==================================================

   a_issue_order : assert property (@(posedge clk) disable iff (rst)
      (issue_valid && issue_ready) |-> ((exp_count != 0) && pkt_match(exp_head, issue_pkt)))
      else report_mismatch("issue order", $sampled(exp_head), $sampled(issue_pkt));

   a_issue_valid : assert property (@(posedge clk) disable iff (rst)
      issue_valid == (buf_cnt_m != 0))
      else report_mismatch("issue valid", $sampled(buf_cnt_m != 0), $sampled(issue_valid));

   a_reg0_idle : assert property (@(posedge clk) disable iff (rst)
      issue_valid |-> !((issue_pkt.uinstr.src1.addr == '0 && issue_pkt.rename.psrc1.pending)
                     || (issue_pkt.uinstr.src2.addr == '0 && issue_pkt.rename.psrc2.pending)))
      else report_mismatch("r0 pending", 0, $sampled(issue_pkt.rename.psrc1.pending));

   a_ready_gate : assert property (@(posedge clk) disable iff (rst || !credit_track)
      ready_out == ready_exp)
      else report_mismatch("ready", $sampled(ready_exp), $sampled(ready_out));

   a_enable_off : assert property (@(posedge clk) disable iff (rst)
      !enable_m |-> !ready_out)
      else report_mismatch("dispatch enable", 0, $sampled(ready_out));

   a_rob_full : assert property (@(posedge clk) disable iff (rst)
      (rob_cnt_m == ROB_DEPTH) |-> !ready_out)
      else report_mismatch("rob full", 0, $sampled(ready_out));

   a_fill_count : assert property (@(posedge clk) disable iff (rst)
      fill_chk |-> (exp_count == fill_expect))
      else report_mismatch("accepted count", $sampled(fill_expect), $sampled(exp_count));

   a_rob_count : assert property (@(posedge clk) disable iff (rst)
      rob_chk |-> (rob_cnt_m == ROB_DEPTH))
      else report_mismatch("robids outstanding", ROB_DEPTH, $sampled(rob_cnt_m));

   // ==================================================
   // Stimulus
   // ==================================================

   // All tasks start and end on a falling edge.
   function automatic core_pkg::t_uinstr make_uop(input int dst, input int s1, input int s2);
      core_pkg::t_uinstr u;
      u.opcode    = 8'($random(seed));
      u.src1.used = 1'b1;
      u.src1.addr = core_pkg::t_reg_addr'(s1);
      u.src2.used = 1'b1;
      u.src2.addr = core_pkg::t_reg_addr'(s2);
      u.dst.used  = 1'b1;
      u.dst.addr  = core_pkg::t_reg_addr'(dst);
      u.imm       = 16'($random(seed));
      u.simid     = uop_id;
      uop_id      = uop_id + 1'b1;
      return u;
   endfunction

   function automatic core_pkg::t_uinstr random_uop();
      logic [31:0] r;
      core_pkg::t_uinstr u;
      r = $random(seed);
      // A small register window keeps dependencies frequent.
      u = make_uop(int'(r[2:0]), int'(r[5:3]), int'(r[8:6]));
      u.dst.used = r[9] | r[10];
      return u;
   endfunction

   task automatic send_uop(input core_pkg::t_uinstr u);
      int start;
      int waited;
      start     = accepted_total;
      waited    = 0;
      valid_in  = 1'b1;
      uinstr_in = u;
      while (accepted_total == start) begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("micro-op was never accepted");
         end
      end
      valid_in = 1'b0;
   endtask

   task automatic stream_uops(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         valid_in  = 1'b1;
         uinstr_in = random_uop();
         @(negedge clk);
      end
      valid_in = 1'b0;
   endtask

   task automatic wait_ready();
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("ready_out never rose");
         end
      end while (!ready_out);
   endtask

   task automatic wait_drain();
      int waited;
      waited      = 0;
      issue_ready = 1'b1;
      while (exp_count != 0) begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("buffer did not drain");
         end
      end
   endtask

   task automatic retire_all();
      int waited;
      waited = 0;
      while (rob_cnt_m != 0) begin
         retire_valid = 1'b1;
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("robids did not retire");
         end
      end
      retire_valid = 1'b0;
   endtask

   task automatic retire_one();
      retire_valid = 1'b1;
      @(negedge clk);
      retire_valid = 1'b0;
   endtask

   task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
      cfg_wr = '{valid: 1'b1, addr: addr, data: data};
      @(negedge clk);
      cfg_wr = '0;
   endtask

   task automatic nuke_pulse();
      nuke_in = '{valid: 1'b1, reason: 16'($random(seed))};
      @(negedge clk);
      nuke_in = '0;
   endtask

   // Fills the buffer with issue held off, checks the count, then drains.
   task automatic check_fill(input int expected);
      issue_ready = 1'b0;
      stream_uops(10);
      fill_expect = expected;
      fill_chk    = 1'b1;
      @(negedge clk);
      fill_chk = 1'b0;
      wait_drain();
      retire_all();
   endtask

   initial begin
      seed         = 32'he71b_7b02;
      uop_id       = '0;
      rst          = 1'b1;
      valid_in     = 1'b0;
      uinstr_in    = '0;
      nuke_in      = '0;
      retire_valid = 1'b0;
      cfg_wr       = '0;
      issue_ready  = 1'b0;
      credit_track = 1'b0;
      fill_chk     = 1'b0;
      rob_chk      = 1'b0;
      fill_expect  = 0;
      test_name    = "reset";
      repeat (3) @(negedge clk);
      rst = 1'b0;

      test_name = "order";
      wait_ready();
      credit_track = 1'b1;
      issue_ready  = 1'b1;
      stream_uops(20);
      wait_drain();
      retire_all();
      stream_uops(20);
      wait_drain();
      retire_all();

      test_name = "rename";
      send_uop(make_uop(3, 1, 2));
      send_uop(make_uop(3, 3, 0));
      send_uop(make_uop(4, 3, 0));
      retire_one();
      send_uop(make_uop(5, 3, 4));
      wait_drain();
      retire_all();
      send_uop(make_uop(6, 3, 0));
      wait_drain();
      retire_all();

      test_name = "credits";
      check_fill(4);
      write_cfg(core_pkg::CFG_CREDIT_LIMIT_ADDR, 8'd2);
      repeat (2) @(negedge clk);
      check_fill(2);

      // Raising the limit only refills the counter on a reload.
      test_name    = "nuke";
      credit_track = 1'b0;
      write_cfg(core_pkg::CFG_CREDIT_LIMIT_ADDR, 8'd4);
      issue_ready = 1'b0;
      send_uop(random_uop());
      retire_one();
      send_uop(random_uop());
      nuke_pulse();
      credit_track = 1'b1;
      repeat (3) @(negedge clk);
      check_fill(4);

      test_name = "enable";
      write_cfg(core_pkg::CFG_ENABLE_ADDR, 8'd0);
      check_fill(0);
      write_cfg(core_pkg::CFG_ENABLE_ADDR, 8'd1);
      send_uop(random_uop());
      wait_drain();
      retire_all();

      test_name   = "rob full";
      issue_ready = 1'b1;
      stream_uops(45);
      rob_chk = 1'b1;
      @(negedge clk);
      rob_chk = 1'b0;
      retire_all();
      send_uop(random_uop());
      wait_drain();
      retire_all();

      $display("PASS: all tests");
      $finish;
   end

endmodule
